// ==== Makefile ====
TOOL     := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := pc_bus_decode_tb
FILELIST := pc_bus_decode.f
SIM_ARGS := +verilator+error+limit+1000
PASS_MSG := TESTS PASSED

OBJ_DIR  := obj_dir
SIM      := $(OBJ_DIR)/V$(TOP)
SOURCES  := $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$($(SIM) $(SIM_ARGS))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== bench/pc_bus_decode_checker.sv ====
// handshake and queue assertions bound into pc_bus_decode
// assert_fails holds the number of failed assertions
`timescale 1ns/1ps
`default_nettype none

module pc_bus_decode_checker import pc_bus_pkg::*; (
   input  wire            clk,
   input  wire            reset_n,
   input  wire            cyc_req_i,
   input  wire            cyc_ack_i,
   input  wire            res_req_i,
   input  decode_result_t res_i,
   input  q_count_t       q_count_i
);

   int unsigned assert_fails = 0;

   // ack may only rise in answer to a request
   ack_rise_needs_req: assert property (@(posedge clk) disable iff (!reset_n)
      $rose(cyc_ack_i) |-> $past(cyc_req_i))
   else begin
      $error("cyc_ack_o rose while cyc_req_i was low");
      assert_fails++;
   end

   res_held_while_req: assert property (@(posedge clk) disable iff (!reset_n)
      (res_req_i && $past(res_req_i)) |-> $stable(res_i))
   else begin
      $error("res_o changed while res_req_o was high");
      assert_fails++;
   end

   queue_not_overfilled: assert property (@(posedge clk) disable iff (!reset_n)
      q_count_i <= q_count_t'(QUEUE_DEPTH))
   else begin
      $error("queue count above depth");
      assert_fails++;
   end

endmodule

`default_nettype wire

// ==== bench/pc_bus_decode_tb.sv ====
// directed and random bus cycles checked against a model of the select decode
// results acknowledged after 0..6 random cycles, which back-pressures the queue
// inputs driven and outputs sampled 1 ns after the rising edge
`timescale 1ns/1ps
`default_nettype none

module pc_bus_decode_tb import pc_bus_pkg::*; ();

   localparam int N_IO   = 32;
   localparam int N_MEM  = 32;
   localparam int N_REG  = 8;
   localparam int N_RAND = 200;
   localparam int TIMEOUT_CYCLES = 40 * (N_IO + N_MEM + N_REG + N_RAND) + 100;
   localparam logic [15:0] LFSR_SEED = 16'd12;
   localparam logic [15:0] LFSR_TAPS = 16'hB400;

   typedef struct packed {
      decode_result_t res;
      page_file_t     pages;   // register state once this cycle is decoded
      logic           nmi;
   } expect_t;

   logic           clk = 1'b0;
   logic           reset_n;
   logic           cyc_req_i;
   bus_cycle_t     cyc_i;
   logic           cyc_ack_o;
   logic           res_req_o;
   decode_result_t res_o;
   logic           res_ack_i;
   page_file_t     page_regs_o;
   logic           nmi_enable_o;

   expect_t     exp_q[$];
   page_file_t  model_pages;
   logic        model_nmi;
   logic [15:0] stim_lfsr = LFSR_SEED;
   logic [15:0] ack_lfsr  = LFSR_SEED;   // separate stream for ack delays
   int errors = 0;
   int checks = 0;
   int issued = 0;
   int tests_run = 0;
   int errors_at_start;
   int checks_at_start;
   int cycle_count = 0;

   always #5 clk = ~clk;

   pc_bus_decode u_pc_bus_decode (
      .clk          (clk),
      .reset_n      (reset_n),
      .cyc_req_i    (cyc_req_i),
      .cyc_i        (cyc_i),
      .cyc_ack_o    (cyc_ack_o),
      .res_req_o    (res_req_o),
      .res_o        (res_o),
      .res_ack_i    (res_ack_i),
      .page_regs_o  (page_regs_o),
      .nmi_enable_o (nmi_enable_o)
   );

   bind pc_bus_decode pc_bus_decode_checker u_checker (
      .clk       (clk),
      .reset_n   (reset_n),
      .cyc_req_i (cyc_req_i),
      .cyc_ack_i (cyc_ack_o),
      .res_req_i (res_req_o),
      .res_i     (res_o),
      .q_count_i (u_queue.count)
   );

   // one galois LFSR step
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
   endfunction

   // n bits, one LFSR step per bit
   task automatic take_bits(inout logic [15:0] state, input int n, output logic [31:0] bits);
      bits = '0;
      for (int i = 0; i < n; i++) begin
         bits  = {bits[30:0], state[0]};
         state = lfsr_next(state);
      end
   endtask

   function automatic bus_cycle_t make_cycle(input bus_addr_t a, input bus_data_t d,
                                             input cycle_kind_e k, input logic dma);
      bus_cycle_t c;
      c.addr      = a;
      c.data      = d;
      c.kind      = k;
      c.dma_owned = dma;
      return c;
   endfunction

   // reference decode rules
   function automatic decode_result_t model_decode(input bus_cycle_t c);
      decode_result_t r;
      sub_idx_t       g;
      logic           io;
      g         = c.addr[7:5];
      io        = (c.kind == KIND_IO_RD) || (c.kind == KIND_IO_WR);
      r.target  = TGT_NONE;
      r.sub_idx = io ? g : 3'd0;
      r.addr    = c.addr;
      if (io && !c.dma_owned && c.addr[9:8] == 2'b00) begin
         if (g == 3'd0)
            r.target = TGT_DMA;
         else if (g == 3'd1)
            r.target = TGT_PIC;
         else if (g == 3'd2)
            r.target = TGT_PIT;
         else if (g == 3'd3)
            r.target = TGT_PPI;
         else if (g == PORT_PAGE_GRP && c.kind == KIND_IO_WR)
            r.target = TGT_PAGE_REG;
         else if (g == PORT_NMI_GRP && c.kind == KIND_IO_WR)
            r.target = TGT_NMI_REG;
      end else if (!io) begin
         if (c.kind == KIND_MEM_RD && c.addr[19:16] == ROM_SEG) begin
            if (c.addr[15:13] >= ROM_FIRST_CHIP) begin
               r.target  = TGT_ROM;
               r.sub_idx = c.addr[15:13];
            end
         end else if (c.addr[19:18] == 2'b00) begin
            r.target  = TGT_RAM;
            r.sub_idx = {1'b0, c.addr[17:16]};
         end
      end
      return r;
   endfunction

   task automatic compare_field(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("MISMATCH t=%0t %s expected %0h got %0h", $time, name, exp, got);
      end
   endtask

   // four-phase offer of one cycle starting at posedge + 1
   task automatic issue_cycle(input bus_cycle_t c);
      expect_t e;
      e.res = model_decode(c);
      if (e.res.target == TGT_PAGE_REG)
         model_pages[c.addr[1:0]] = c.data[3:0];
      if (e.res.target == TGT_NMI_REG)
         model_nmi = c.data[7];
      e.pages = model_pages;
      e.nmi   = model_nmi;
      exp_q.push_back(e);
      issued++;
      cyc_i     = c;
      cyc_req_i = 1'b1;
      @(posedge clk);
      #1;
      while (!cyc_ack_o) begin
         @(posedge clk);
         #1;
      end
      cyc_req_i = 1'b0;
      @(posedge clk);
      #1;
      while (cyc_ack_o) begin
         @(posedge clk);
         #1;
      end
   endtask

   task automatic drain_results();
      while (exp_q.size() != 0 || res_req_o) begin
         @(posedge clk);
         #1;
      end
      repeat (3) begin   // room for a stray extra result
         @(posedge clk);
         #1;
      end
   endtask

   task automatic begin_test();
      errors_at_start = errors;
      checks_at_start = checks;
   endtask

   task automatic end_test(input string name);
      tests_run++;
      $display("test %-12s done: %0d checks, %0d errors", name,
               checks - checks_at_start, errors - errors_at_start);
   endtask

   task automatic run_reset_test();
      begin_test();
      @(posedge clk);
      #1;
      compare_field("cyc_ack_o", 32'(cyc_ack_o), 32'd0);
      compare_field("res_req_o", 32'(res_req_o), 32'd0);
      compare_field("page_regs_o", 32'(page_regs_o), 32'd0);
      compare_field("nmi_enable_o", 32'(nmi_enable_o), 32'd0);
      end_test("reset");
   endtask

   task automatic run_io_test();
      logic [31:0] v;
      bus_addr_t   a;
      begin_test();
      for (int g = 0; g < 8; g++) begin
         take_bits(stim_lfsr, 28, v);
         a       = v[19:0];
         a[9:8]  = 2'b00;
         a[7:5]  = 3'(g);
         issue_cycle(make_cycle(a, v[27:20], KIND_IO_RD, 1'b0));
         issue_cycle(make_cycle(a, v[27:20], KIND_IO_WR, 1'b0));
         issue_cycle(make_cycle(a | (g[0] ? 20'h200 : 20'h100), v[27:20], KIND_IO_WR, 1'b0));
         issue_cycle(make_cycle(a, v[27:20], g[1] ? KIND_IO_WR : KIND_IO_RD, 1'b1));
      end
      drain_results();
      end_test("io_decode");
   endtask

   task automatic run_mem_test();
      logic [31:0] v;
      bus_addr_t   a;
      begin_test();
      for (int chip = 0; chip < 8; chip++) begin
         take_bits(stim_lfsr, 21, v);
         a = {ROM_SEG, 3'(chip), v[12:0]};
         issue_cycle(make_cycle(a, v[20:13], KIND_MEM_RD, 1'b0));
         issue_cycle(make_cycle(a, v[20:13], KIND_MEM_WR, 1'b0));   // writes never hit ROM
      end
      for (int bank = 0; bank < 4; bank++) begin
         take_bits(stim_lfsr, 24, v);
         a = {2'b00, 2'(bank), v[15:0]};
         issue_cycle(make_cycle(a, v[23:16], KIND_MEM_RD, 1'b0));
         issue_cycle(make_cycle(a, v[23:16], KIND_MEM_WR, 1'b0));
      end
      for (int k = 0; k < 4; k++) begin
         take_bits(stim_lfsr, 24, v);
         a = {4'(4 + 3 * k), v[15:0]};   // segments 4, 7, A, D
         issue_cycle(make_cycle(a, v[23:16], KIND_MEM_RD, 1'b0));
         issue_cycle(make_cycle(a, v[23:16], KIND_MEM_WR, 1'b0));
      end
      drain_results();
      end_test("mem_decode");
   endtask

   task automatic run_reg_test();
      logic [31:0] v;
      bus_addr_t   a;
      begin_test();
      for (int slot = 0; slot < 4; slot++) begin
         take_bits(stim_lfsr, 18, v);
         a = {v[9:0], 2'b00, PORT_PAGE_GRP, 3'b000, 2'(slot)};
         issue_cycle(make_cycle(a, v[17:10], KIND_IO_WR, 1'b0));
      end
      take_bits(stim_lfsr, 17, v);
      a = {v[9:0], 2'b00, PORT_NMI_GRP, 5'b00000};
      issue_cycle(make_cycle(a, {1'b1, v[16:10]}, KIND_IO_WR, 1'b0));
      issue_cycle(make_cycle(a, {1'b0, v[16:10]}, KIND_IO_WR, 1'b0));
      // DMA-owned writes must leave both registers unchanged
      issue_cycle(make_cycle(a, 8'h80, KIND_IO_WR, 1'b1));
      a[7:5] = PORT_PAGE_GRP;
      issue_cycle(make_cycle(a, {4'h0, ~model_pages[0]}, KIND_IO_WR, 1'b1));
      drain_results();
      end_test("board_regs");
   endtask

   task automatic random_cycle(output bus_cycle_t c);
      logic [31:0] v;
      take_bits(stim_lfsr, 20, v);
      c.addr = v[19:0];
      take_bits(stim_lfsr, 8, v);
      c.data = v[7:0];
      take_bits(stim_lfsr, 2, v);
      c.kind = cycle_kind_e'(v[1:0]);
      take_bits(stim_lfsr, 3, v);
      c.dma_owned = (v[2:0] == 3'd0);   // about one in eight
      take_bits(stim_lfsr, 1, v);
      if (v[0] && (c.kind == KIND_IO_RD || c.kind == KIND_IO_WR))
         c.addr[9:8] = 2'b00;           // favour on-board ports
   endtask

   task automatic run_random_test();
      bus_cycle_t c;
      begin_test();
      for (int n = 0; n < N_RAND; n++) begin
         random_cycle(c);
         issue_cycle(c);
      end
      drain_results();
      end_test("random_order");
   endtask

   // result side compares in issue order and acks after a random delay
   initial begin
      expect_t     e;
      logic [31:0] v;
      int          delay;
      res_ack_i = 1'b0;
      @(posedge reset_n);
      forever begin
         @(posedge clk);
         #1;
         if (res_req_o) begin
            if (exp_q.size() == 0) begin
               errors++;
               $display("ERROR t=%0t: result for addr %h with no cycle outstanding",
                        $time, res_o.addr);
            end else begin
               e = exp_q.pop_front();
               compare_field("res_o.target", 32'(res_o.target), 32'(e.res.target));
               compare_field("res_o.sub_idx", 32'(res_o.sub_idx), 32'(e.res.sub_idx));
               compare_field("res_o.addr", 32'(res_o.addr), 32'(e.res.addr));
               compare_field("page_regs_o", 32'(page_regs_o), 32'(e.pages));
               compare_field("nmi_enable_o", 32'(nmi_enable_o), 32'(e.nmi));
            end
            take_bits(ack_lfsr, 3, v);
            delay = int'(v[2:0]) % 7;
            repeat (delay) begin
               @(posedge clk);
               #1;
            end
            res_ack_i = 1'b1;
            @(posedge clk);
            #1;
            while (res_req_o) begin
               @(posedge clk);
               #1;
            end
            res_ack_i = 1'b0;
         end
      end
   end

   // run limit
   initial begin
      while (cycle_count < TIMEOUT_CYCLES) begin
         @(posedge clk);
         cycle_count++;
      end
      $display("ERROR: timeout after %0d cycles, a handshake never completed", cycle_count);
      $display("TESTS FAILED");
      $finish;
   end

   initial begin
      reset_n     = 1'b0;
      cyc_req_i   = 1'b0;
      cyc_i       = '0;
      model_pages = '0;
      model_nmi   = 1'b0;
      repeat (2) @(posedge clk);
      #1;
      reset_n = 1'b1;
      run_reset_test();
      run_io_test();
      run_mem_test();
      run_reg_test();
      run_random_test();
      if (u_pc_bus_decode.u_checker.assert_fails != 0) begin
         errors += int'(u_pc_bus_decode.u_checker.assert_fails);
         $display("ERROR: %0d assertion failures in the bound checker",
                  u_pc_bus_decode.u_checker.assert_fails);
      end
      $display("summary: %0d tests, %0d cycles issued, %0d checks, %0d errors",
               tests_run, issued, checks, errors);
      if (errors == 0)
         $display("TESTS PASSED");
      else
         $display("TESTS FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// ==== design/cycle_capture.sv ====
// acknowledge side of the four-phase input handshake
// cyc_i must stay stable while cyc_req_i is high and cyc_ack_o is low
`timescale 1ns/1ps
`default_nettype none

module cycle_capture import pc_bus_pkg::*; (
   input  wire        clk,
   input  wire        reset_n,
   input  wire        cyc_req_i,
   input  bus_cycle_t cyc_i,
   output logic       cyc_ack_o,
   output logic       push_valid_o,
   output bus_cycle_t push_cycle_o,
   input  wire        push_ready_i
);

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_PUSH,
      ST_ACK_HIGH
   } cap_state_e;

   cap_state_e state;
   bus_cycle_t cyc_q;   // latched cycle, like the address latches

   // control
   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) begin
         state <= ST_IDLE;
      end else begin
         case (state)
            ST_IDLE: begin
               if (cyc_req_i)
                  state <= ST_PUSH;
            end
            ST_PUSH: begin
               if (push_ready_i)
                  state <= ST_ACK_HIGH;   // queue took it, ack rises here
            end
            ST_ACK_HIGH: begin
               if (!cyc_req_i)
                  state <= ST_IDLE;       // requester let go
            end
            default: state <= ST_IDLE;
         endcase
      end
   end

   // capture only on the first edge of a new request
   always_ff @(posedge clk) begin
      if (state == ST_IDLE && cyc_req_i)
         cyc_q <= cyc_i;
   end

   assign push_valid_o = (state == ST_PUSH);
   assign push_cycle_o = cyc_q;
   assign cyc_ack_o    = (state == ST_ACK_HIGH);   // straight from state flops

endmodule

`default_nettype wire

// ==== design/cycle_queue.sv ====
// small circular FIFO between capture and decode, QUEUE_DEPTH entries
// a push and a pop on the same edge are both taken
// no push while full, even when a pop happens on that edge
`timescale 1ns/1ps
`default_nettype none

module cycle_queue import pc_bus_pkg::*; (
   input  wire        clk,
   input  wire        reset_n,
   input  wire        in_valid_i,
   input  bus_cycle_t in_cycle_i,
   output logic       in_ready_o,
   output logic       out_valid_o,
   output bus_cycle_t out_cycle_o,
   input  wire        out_ready_i
);

   bus_cycle_t mem [QUEUE_DEPTH];
   q_ptr_t     wr_ptr;
   q_ptr_t     rd_ptr;
   q_count_t   count;    // occupancy
   logic       push;
   logic       pop;

   // wrap for depths that are not a power of two
   function automatic q_ptr_t next_ptr(input q_ptr_t ptr);
      if (ptr == q_ptr_t'(QUEUE_DEPTH - 1))
         return '0;
      else
         return ptr + 1'b1;
   endfunction

   assign in_ready_o  = (count != q_count_t'(QUEUE_DEPTH));
   assign out_valid_o = (count != '0);
   assign push        = in_valid_i && in_ready_o;
   assign pop         = out_valid_o && out_ready_i;

   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push)
            wr_ptr <= next_ptr(wr_ptr);
         if (pop)
            rd_ptr <= next_ptr(rd_ptr);
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;    // none, or both at once
         endcase
      end
   end

   // storage
   always_ff @(posedge clk) begin
      if (push)
         mem[wr_ptr] <= in_cycle_i;
   end

   assign out_cycle_o = mem[rd_ptr];   // head entry, valid one cycle after its write

endmodule

`default_nettype wire

// ==== design/pc_bus_decode.sv ====
// bus-cycle select decoder, capture -> queue -> decode
// up to three cycles in flight, latency varies with result acknowledge
`timescale 1ns/1ps
`default_nettype none

module pc_bus_decode import pc_bus_pkg::*; (
   input  wire            clk,
   input  wire            reset_n,
   input  wire            cyc_req_i,
   input  bus_cycle_t     cyc_i,
   output logic           cyc_ack_o,
   output logic           res_req_o,
   output decode_result_t res_o,
   input  wire            res_ack_i,
   output page_file_t     page_regs_o,
   output logic           nmi_enable_o
);

   logic       cap_valid;   // capture -> queue
   bus_cycle_t cap_cycle;
   logic       cap_ready;
   logic       dec_valid;   // queue -> decoder
   bus_cycle_t dec_cycle;
   logic       dec_ready;

   cycle_capture u_capture (
      .clk          (clk),
      .reset_n      (reset_n),
      .cyc_req_i    (cyc_req_i),
      .cyc_i        (cyc_i),
      .cyc_ack_o    (cyc_ack_o),
      .push_valid_o (cap_valid),
      .push_cycle_o (cap_cycle),
      .push_ready_i (cap_ready)
   );

   cycle_queue u_queue (
      .clk         (clk),
      .reset_n     (reset_n),
      .in_valid_i  (cap_valid),
      .in_cycle_i  (cap_cycle),
      .in_ready_o  (cap_ready),
      .out_valid_o (dec_valid),
      .out_cycle_o (dec_cycle),
      .out_ready_i (dec_ready)
   );

   select_decoder u_decoder (
      .clk          (clk),
      .reset_n      (reset_n),
      .in_valid_i   (dec_valid),
      .in_cycle_i   (dec_cycle),
      .in_ready_o   (dec_ready),
      .res_req_o    (res_req_o),
      .res_o        (res_o),
      .res_ack_i    (res_ack_i),
      .page_regs_o  (page_regs_o),
      .nmi_enable_o (nmi_enable_o)
   );

endmodule

`default_nettype wire

// ==== design/pc_bus_pkg.sv ====
// cycle and result formats shared by the capture, queue and decoder blocks
// I/O port groups follow the system-board 8-way decode of address bits 7..5
// page register file is write-only, read back only through the top-level port
`default_nettype none

package pc_bus_pkg;

   localparam int ADDR_W        = 20;
   localparam int DATA_W        = 8;
   localparam int QUEUE_DEPTH   = 2;
   localparam int QPTR_W        = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
   localparam int QCNT_W        = $clog2(QUEUE_DEPTH + 1);
   localparam int PAGE_SEL_W    = 2;              // page slot from address bits 1..0
   localparam int NUM_PAGE_REGS = 1 << PAGE_SEL_W;

   typedef logic [ADDR_W-1:0] bus_addr_t;
   typedef logic [DATA_W-1:0] bus_data_t;
   typedef logic [3:0]        page_t;             // upper address nibble for DMA
   typedef page_t [NUM_PAGE_REGS-1:0] page_file_t;
   typedef logic [2:0]        sub_idx_t;          // rom chip, ram bank or port group
   typedef logic [QPTR_W-1:0] q_ptr_t;
   typedef logic [QCNT_W-1:0] q_count_t;

   localparam logic [3:0] ROM_SEG        = 4'hF;  // F0000..FFFFF
   localparam sub_idx_t   ROM_FIRST_CHIP = 3'd2;  // chips 0,1 not populated
   localparam sub_idx_t   PORT_PAGE_GRP  = 3'd4;
   localparam sub_idx_t   PORT_NMI_GRP   = 3'd5;

   typedef enum logic [1:0] {
      KIND_MEM_RD,
      KIND_MEM_WR,
      KIND_IO_RD,
      KIND_IO_WR
   } cycle_kind_e;

   typedef enum logic [3:0] {
      TGT_NONE,
      TGT_DMA,
      TGT_PIC,
      TGT_PIT,
      TGT_PPI,
      TGT_PAGE_REG,
      TGT_NMI_REG,
      TGT_ROM,
      TGT_RAM
   } target_e;

   typedef struct packed {
      bus_addr_t   addr;
      bus_data_t   data;
      cycle_kind_e kind;
      logic        dma_owned;   // cycle driven while the DMA owns the bus
   } bus_cycle_t;

   typedef struct packed {
      target_e   target;
      sub_idx_t  sub_idx;
      bus_addr_t addr;
   } decode_result_t;

endpackage

`default_nettype wire

// ==== design/select_decoder.sv ====
// decodes one cycle at a time and offers the result on a four-phase handshake
// page and NMI registers are written on the same edge that registers the result
// memory cycles that give none carry sub-index 0, I/O cycles always carry the group
`timescale 1ns/1ps
`default_nettype none

module select_decoder import pc_bus_pkg::*; (
   input  wire            clk,
   input  wire            reset_n,
   input  wire            in_valid_i,
   input  bus_cycle_t     in_cycle_i,
   output logic           in_ready_o,
   output logic           res_req_o,
   output decode_result_t res_o,
   input  wire            res_ack_i,
   output page_file_t     page_regs_o,
   output logic           nmi_enable_o
);

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_PRESENT,
      ST_WAIT_DROP
   } dec_state_e;

   dec_state_e     state;
   decode_result_t dec;
   decode_result_t res_q;
   page_file_t     page_regs_q;
   logic           nmi_enable_q;
   logic           pop;

   function automatic decode_result_t decode_cycle(input bus_cycle_t cyc);
      decode_result_t r;
      sub_idx_t       grp;
      sub_idx_t       chip;
      logic           is_wr;
      r.target  = TGT_NONE;
      r.sub_idx = '0;
      r.addr    = cyc.addr;
      grp   = cyc.addr[7:5];
      chip  = cyc.addr[15:13];
      is_wr = (cyc.kind == KIND_IO_WR);
      case (cyc.kind)
         KIND_IO_RD, KIND_IO_WR: begin
            r.sub_idx = grp;
            // 8/9 qualify the on-board port space, DMA cycles never select a port
            if (!cyc.dma_owned && !cyc.addr[9] && !cyc.addr[8]) begin
               case (grp)
                  3'd0:          r.target = TGT_DMA;
                  3'd1:          r.target = TGT_PIC;
                  3'd2:          r.target = TGT_PIT;
                  3'd3:          r.target = TGT_PPI;
                  PORT_PAGE_GRP: r.target = is_wr ? TGT_PAGE_REG : TGT_NONE;
                  PORT_NMI_GRP:  r.target = is_wr ? TGT_NMI_REG : TGT_NONE;
                  default:       r.target = TGT_NONE;
               endcase
            end
         end
         default: begin
            if (cyc.kind == KIND_MEM_RD && cyc.addr[ADDR_W-1 -: 4] == ROM_SEG) begin
               if (chip >= ROM_FIRST_CHIP) begin   // empty sockets stay none
                  r.target  = TGT_ROM;
                  r.sub_idx = chip;
               end
            end else if (cyc.addr[19:18] == 2'b00) begin
               r.target  = TGT_RAM;               // low 256K, four banks
               r.sub_idx = {1'b0, cyc.addr[17:16]};
            end
         end
      endcase
      return r;
   endfunction

   assign dec        = decode_cycle(in_cycle_i);
   assign in_ready_o = (state == ST_IDLE);
   assign pop        = in_valid_i && in_ready_o;

   // handshake and board registers
   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) begin
         state        <= ST_IDLE;
         page_regs_q  <= '0;
         nmi_enable_q <= 1'b0;
      end else begin
         case (state)
            ST_IDLE: begin
               if (pop) begin
                  state <= ST_PRESENT;
                  if (dec.target == TGT_PAGE_REG)
                     page_regs_q[in_cycle_i.addr[PAGE_SEL_W-1:0]] <= in_cycle_i.data[3:0];
                  if (dec.target == TGT_NMI_REG)
                     nmi_enable_q <= in_cycle_i.data[7];   // bit 7 gates NMI
               end
            end
            ST_PRESENT: begin
               if (res_ack_i)
                  state <= ST_WAIT_DROP;   // req drops
            end
            ST_WAIT_DROP: begin
               if (!res_ack_i)
                  state <= ST_IDLE;
            end
            default: state <= ST_IDLE;
         endcase
      end
   end

   // result payload, held until the next pop
   always_ff @(posedge clk) begin
      if (pop)
         res_q <= dec;
   end

   assign res_req_o    = (state == ST_PRESENT);
   assign res_o        = res_q;
   assign page_regs_o  = page_regs_q;
   assign nmi_enable_o = nmi_enable_q;

endmodule

`default_nettype wire

// ==== pc_bus_decode.f ====
design/pc_bus_pkg.sv
design/cycle_capture.sv
design/cycle_queue.sv
design/select_decoder.sv
design/pc_bus_decode.sv
bench/pc_bus_decode_checker.sv
bench/pc_bus_decode_tb.sv
